//--- logic/transmit_config.svh
// Size definitions for the DAC transmit path.
// Include this before using the transmit package or any transmit RTL block.

`ifndef TRANSMIT_CONFIG_SVH
`define TRANSMIT_CONFIG_SVH

// number of DAC channels
`define TX_CHANNELS 2

// sample word, signed
`define TX_SAMPLE_W 16

// triangle phase accumulator
`define TX_PHASE_W 32

// unsigned scale, 2 integer bits, unity gain is 0x10000
`define TX_SCALE_W 18

// signed offset, lines up with the top 14 bits of a sample
`define TX_OFFSET_W 14

// AWG entries per channel
`define TX_AWG_DEPTH 32

// AWG burst count
`define TX_BURST_W 16

`endif

//--- logic/transmit_pkg.sv
// Types shared by the DAC transmit path blocks and their testbench.
// Samples, configuration payloads and the DAC output word live here.

`include "transmit_config.svh"

package transmit_pkg;

  typedef logic signed [`TX_SAMPLE_W-1:0] sample_t;

  // one sample per channel, channel 0 in the low word
  typedef sample_t [`TX_CHANNELS-1:0] sample_vec_t;

  typedef logic [`TX_CHANNELS-1:0][`TX_PHASE_W-1:0] phase_inc_t;

  typedef struct packed {
    logic [`TX_SCALE_W-1:0]         scale;
    logic signed [`TX_OFFSET_W-1:0] offset;
  } scale_offset_t;

  typedef scale_offset_t [`TX_CHANNELS-1:0] scale_offset_vec_t;

  // zero must stay at code 0, the reset value of the selector
  typedef enum logic [1:0] {
    src_zero = 2'd0,
    src_awg  = 2'd1,
    src_tri  = 2'd2
  } source_t;

  typedef source_t [`TX_CHANNELS-1:0] source_sel_t;

  typedef struct packed {
    logic use_awg;
    logic use_tri;
  } trigger_cfg_t;

  typedef struct packed {
    logic                   start;
    logic                   stop;
    logic [`TX_BURST_W-1:0] burst_count;
  } awg_ctrl_t;

  typedef struct packed {
    sample_vec_t samples;
    logic        last;
  } dma_beat_t;

  typedef struct packed {
    logic        valid;
    sample_vec_t samples;
  } dac_out_t;

endpackage

//--- logic/config_reg.sv
// Holding register for one configuration stream.
// Accepts a payload over valid/ready and flags each new value for one cycle.

`timescale 1ns/1ps

module config_reg #(
  parameter type payload_t = logic
) (
  input  logic     ps_clk,
  input  logic     ps_reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output payload_t value,
  output logic     update
);

  logic accept;

  assign accept = in_valid & in_ready;

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      in_ready <= 1'b0;
      value    <= '0;
      update   <= 1'b0;
    end else begin
      // always ready once out of reset
      in_ready <= 1'b1;
      update   <= accept;
      if (accept) begin
        value <= in_data;
      end
    end
  end

endmodule

//--- logic/awg_buffer.sv
// AWG sample buffer. One frame is loaded over the DMA stream while stopped,
// then played out as a burst of repeated frames with a trigger on entry 0.

`include "transmit_config.svh"
`timescale 1ns/1ps

module awg_buffer (
  input  logic                      ps_clk,
  input  logic                      ps_reset,
  input  logic                      dma_valid,
  output logic                      dma_ready,
  input  transmit_pkg::dma_beat_t   dma_data,
  input  transmit_pkg::awg_ctrl_t   ctrl,
  input  logic                      ctrl_update,
  output transmit_pkg::sample_vec_t samples,
  output logic                      trigger
);
  import transmit_pkg::*;

  localparam int ADDR_W = $clog2(`TX_AWG_DEPTH);
  localparam int CNT_W  = ADDR_W + 1;
  localparam logic [CNT_W-1:0] FULL = CNT_W'(`TX_AWG_DEPTH);

  // load side
  logic             load_en;
  logic             dma_fire;
  logic             wr_en;
  logic [CNT_W-1:0] wr_ptr;
  logic [CNT_W-1:0] depth;

  // playback side
  logic                   playing;
  logic                   halt;
  logic                   active;
  logic                   frame_end;
  logic [ADDR_W-1:0]      rd_ptr;
  logic [`TX_BURST_W-1:0] bursts_left;

  // no loading while a burst is running
  assign dma_ready = load_en & ~playing;
  assign dma_fire  = dma_valid & dma_ready;
  assign wr_en     = dma_fire & (wr_ptr < FULL);

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      load_en <= 1'b0;
      wr_ptr  <= '0;
      depth   <= '0;
    end else begin
      load_en <= 1'b1;
      if (dma_fire) begin
        if (dma_data.last) begin
          wr_ptr <= '0;
          // beats past the end were dropped, so clamp the depth
          depth  <= (wr_ptr == FULL) ? FULL : wr_ptr + 1'b1;
        end else if (wr_ptr != FULL) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  // stop takes effect in the cycle it arrives
  assign halt      = ctrl_update & ctrl.stop;
  assign active    = playing & ~halt;
  assign frame_end = ({1'b0, rd_ptr} == depth - 1'b1);

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      playing     <= 1'b0;
      rd_ptr      <= '0;
      bursts_left <= '0;
    end else if (halt) begin
      playing <= 1'b0;
    end else if (ctrl_update && ctrl.start && depth != '0) begin
      playing     <= (ctrl.burst_count != '0);
      rd_ptr      <= '0;
      bursts_left <= ctrl.burst_count;
    end else if (playing) begin
      if (frame_end) begin
        rd_ptr      <= '0;
        bursts_left <= bursts_left - 1'b1;
        // last frame of the burst
        playing     <= (bursts_left != `TX_BURST_W'(1));
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  for (genvar ch = 0; ch < `TX_CHANNELS; ch++) begin : g_chan
    sample_t mem [`TX_AWG_DEPTH];

    always_ff @(posedge ps_clk) begin
      if (wr_en) begin
        mem[wr_ptr[ADDR_W-1:0]] <= dma_data.samples[ch];
      end
    end

    assign samples[ch] = active ? mem[rd_ptr] : '0;
  end

  assign trigger = active & (rd_ptr == '0);

endmodule

//--- logic/triangle_gen.sv
// Triangle generator, one phase accumulator per channel.
// A restart clears all phases; the trigger marks each channel-0 phase wrap.

`include "transmit_config.svh"
`timescale 1ns/1ps

module triangle_gen (
  input  logic                      ps_clk,
  input  logic                      ps_reset,
  input  transmit_pkg::phase_inc_t  phase_inc,
  input  logic                      restart,
  output transmit_pkg::sample_vec_t samples,
  output logic                      trigger
);
  import transmit_pkg::*;

  phase_inc_t           phase;
  logic [`TX_PHASE_W:0] sum0;

  // carry out of channel 0 is the wrap
  assign sum0 = {1'b0, phase[0]} + {1'b0, phase_inc[0]};

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      phase   <= '0;
      trigger <= 1'b0;
    end else if (restart) begin
      phase   <= '0;
      trigger <= 1'b0;
    end else begin
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        phase[ch] <= phase[ch] + phase_inc[ch];
      end
      trigger <= sum0[`TX_PHASE_W];
    end
  end

  for (genvar ch = 0; ch < `TX_CHANNELS; ch++) begin : g_chan
    logic [`TX_SAMPLE_W-1:0] fold;

    // bits under the MSB, mirrored in the second half of the period
    assign fold = phase[ch][`TX_PHASE_W-2 -: `TX_SAMPLE_W]
                  ^ {`TX_SAMPLE_W{phase[ch][`TX_PHASE_W-1]}};

    // offset binary to two's complement, phase 0 gives the most negative value
    assign samples[ch] = {~fold[`TX_SAMPLE_W-1], fold[`TX_SAMPLE_W-2:0]};
  end

endmodule

//--- logic/source_select.sv
// Per-channel source selector between the AWG, the triangle and zero.
// The chosen sample is registered, adding one cycle to the path.

`include "transmit_config.svh"
`timescale 1ns/1ps

module source_select (
  input  logic                      ps_clk,
  input  logic                      ps_reset,
  input  transmit_pkg::source_sel_t sel,
  input  transmit_pkg::sample_vec_t awg,
  input  transmit_pkg::sample_vec_t triangle,
  output transmit_pkg::sample_vec_t samples
);
  import transmit_pkg::*;

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      samples <= '0;
    end else begin
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        case (sel[ch])
          src_awg: begin
            samples[ch] <= awg[ch];
          end
          src_tri: begin
            samples[ch] <= triangle[ch];
          end
          // zero source and unused codes
          default: begin
            samples[ch] <= '0;
          end
        endcase
      end
    end
  end

endmodule

//--- logic/sample_prescaler.sv
// Per-channel scale and offset with saturation, one register stage.
// Also produces the DAC output valid flag once the pipeline has filled.

`include "transmit_config.svh"
`timescale 1ns/1ps

module sample_prescaler (
  input  logic                            ps_clk,
  input  logic                            ps_reset,
  input  transmit_pkg::scale_offset_vec_t cfg,
  input  transmit_pkg::sample_vec_t       samples,
  output transmit_pkg::dac_out_t          dac
);
  import transmit_pkg::*;

  localparam int PROD_W   = `TX_SAMPLE_W + `TX_SCALE_W + 1;
  localparam int SCALED_W = PROD_W - 16;
  localparam int SUM_W    = SCALED_W + 1;

  logic [1:0]  warm;
  logic        valid_q;
  sample_vec_t samples_q;

  function automatic sample_t prescale(input sample_t x, input scale_offset_t c);
    logic signed [PROD_W-1:0]   prod;
    logic signed [SCALED_W-1:0] scaled;
    logic signed [SUM_W-1:0]    sum;
    prod   = x * $signed({1'b0, c.scale});
    // arithmetic shift by 16, truncating
    scaled = prod[PROD_W-1:16];
    sum    = scaled + $signed({c.offset, 2'b00});
    // fits when all bits from the sign of a sample upward agree
    if (sum[SUM_W-1:`TX_SAMPLE_W-1] == '0 || sum[SUM_W-1:`TX_SAMPLE_W-1] == '1) begin
      return sample_t'(sum[`TX_SAMPLE_W-1:0]);
    end else if (sum[SUM_W-1]) begin
      return {1'b1, {(`TX_SAMPLE_W-1){1'b0}}};
    end else begin
      return {1'b0, {(`TX_SAMPLE_W-1){1'b1}}};
    end
  endfunction

  // valid rises on the third cycle out of reset
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      warm    <= '0;
      valid_q <= 1'b0;
    end else begin
      warm    <= {warm[0], 1'b1};
      valid_q <= warm[1];
    end
  end

  always_ff @(posedge ps_clk) begin
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      samples_q[ch] <= prescale(samples[ch], cfg[ch]);
    end
  end

  assign dac.valid   = valid_q;
  assign dac.samples = samples_q;

endmodule

//--- logic/trigger_manager.sv
// Combines the enabled source triggers into the single DAC trigger.
// Two register stages keep it aligned with the sample pipeline.

`timescale 1ns/1ps

module trigger_manager (
  input  logic                       ps_clk,
  input  logic                       ps_reset,
  input  transmit_pkg::trigger_cfg_t cfg,
  input  logic                       awg_trigger,
  input  logic                       tri_trigger,
  output logic                       dac_trigger
);

  logic trig_d;

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      trig_d      <= 1'b0;
      dac_trigger <= 1'b0;
    end else begin
      trig_d      <= (cfg.use_awg & awg_trigger) | (cfg.use_tri & tri_trigger);
      dac_trigger <= trig_d;
    end
  end

endmodule

//--- logic/transmit_top.sv
// Top of the DAC transmit path: configuration registers, AWG, triangle,
// source selector, prescaler and trigger manager, all on ps_clk.

`timescale 1ns/1ps

module transmit_top (
  input  logic                            ps_clk,
  input  logic                            ps_reset,
  input  logic                            scale_offset_valid,
  output logic                            scale_offset_ready,
  input  transmit_pkg::scale_offset_vec_t scale_offset_data,
  input  logic                            tri_phase_inc_valid,
  output logic                            tri_phase_inc_ready,
  input  transmit_pkg::phase_inc_t        tri_phase_inc_data,
  input  logic                            source_sel_valid,
  output logic                            source_sel_ready,
  input  transmit_pkg::source_sel_t       source_sel_data,
  input  logic                            trigger_cfg_valid,
  output logic                            trigger_cfg_ready,
  input  transmit_pkg::trigger_cfg_t      trigger_cfg_data,
  input  logic                            awg_ctrl_valid,
  output logic                            awg_ctrl_ready,
  input  transmit_pkg::awg_ctrl_t         awg_ctrl_data,
  input  logic                            awg_dma_valid,
  output logic                            awg_dma_ready,
  input  transmit_pkg::dma_beat_t         awg_dma_data,
  output transmit_pkg::dac_out_t          dac_out,
  output logic                            dac_trigger
);
  import transmit_pkg::*;

  // held configuration
  scale_offset_vec_t scale_offset;
  phase_inc_t        tri_phase_inc;
  logic              tri_restart;
  source_sel_t       source_sel;
  trigger_cfg_t      trigger_cfg;
  awg_ctrl_t         awg_ctrl;
  logic              awg_ctrl_update;

  // generator outputs
  sample_vec_t awg_samples;
  sample_vec_t tri_samples;
  sample_vec_t sel_samples;
  logic        awg_trigger;
  logic        tri_trigger;

  config_reg #(.payload_t(scale_offset_vec_t)) scale_offset_reg (
    .ps_clk, .ps_reset,
    .in_valid (scale_offset_valid), .in_ready (scale_offset_ready),
    .in_data  (scale_offset_data), .value (scale_offset), .update ()
  );

  config_reg #(.payload_t(phase_inc_t)) tri_phase_inc_reg (
    .ps_clk, .ps_reset,
    .in_valid (tri_phase_inc_valid), .in_ready (tri_phase_inc_ready),
    .in_data  (tri_phase_inc_data), .value (tri_phase_inc), .update (tri_restart)
  );

  config_reg #(.payload_t(source_sel_t)) source_sel_reg (
    .ps_clk, .ps_reset,
    .in_valid (source_sel_valid), .in_ready (source_sel_ready),
    .in_data  (source_sel_data), .value (source_sel), .update ()
  );

  config_reg #(.payload_t(trigger_cfg_t)) trigger_cfg_reg (
    .ps_clk, .ps_reset,
    .in_valid (trigger_cfg_valid), .in_ready (trigger_cfg_ready),
    .in_data  (trigger_cfg_data), .value (trigger_cfg), .update ()
  );

  config_reg #(.payload_t(awg_ctrl_t)) awg_ctrl_reg (
    .ps_clk, .ps_reset,
    .in_valid (awg_ctrl_valid), .in_ready (awg_ctrl_ready),
    .in_data  (awg_ctrl_data), .value (awg_ctrl), .update (awg_ctrl_update)
  );

  awg_buffer awg (
    .ps_clk, .ps_reset,
    .dma_valid (awg_dma_valid), .dma_ready (awg_dma_ready), .dma_data (awg_dma_data),
    .ctrl (awg_ctrl), .ctrl_update (awg_ctrl_update),
    .samples (awg_samples), .trigger (awg_trigger)
  );

  triangle_gen triangle (
    .ps_clk, .ps_reset,
    .phase_inc (tri_phase_inc), .restart (tri_restart),
    .samples (tri_samples), .trigger (tri_trigger)
  );

  source_select select (
    .ps_clk, .ps_reset,
    .sel (source_sel), .awg (awg_samples), .triangle (tri_samples),
    .samples (sel_samples)
  );

  sample_prescaler prescaler (
    .ps_clk, .ps_reset,
    .cfg (scale_offset), .samples (sel_samples), .dac (dac_out)
  );

  trigger_manager trig (
    .ps_clk, .ps_reset,
    .cfg (trigger_cfg), .awg_trigger, .tri_trigger, .dac_trigger
  );

endmodule

//--- tb/transmit_tb_clock.sv
// Free-running clock for the transmit path testbench.
// Instantiated once by the testbench top, period given in ns.

`timescale 1ns/1ps

module transmit_tb_clock #(
  parameter int PERIOD = 20
) (
  output logic ps_clk
);

  initial begin
    ps_clk = 1'b0;
    forever #(PERIOD / 2) ps_clk = ~ps_clk;
  end

endmodule

//--- tb/transmit_top_tb.sv
// Testbench for the DAC transmit path. Drives the config and DMA streams on the
// falling edge, predicts dac_out and dac_trigger per cycle and compares them.

`include "transmit_config.svh"
`timescale 1ns/1ps

module transmit_top_tb;
  import transmit_pkg::*;

  localparam int LOG_LEN    = 2048;
  localparam int WAIT_LIMIT = 100;
  localparam longint SAT_HI = (longint'(1) << (`TX_SAMPLE_W - 1)) - 1;
  localparam longint SAT_LO = -SAT_HI - 1;

  // stream index into in_valid and ready
  localparam int ST_SCALE  = 0;
  localparam int ST_PHASE  = 1;
  localparam int ST_SOURCE = 2;
  localparam int ST_TRIG   = 3;
  localparam int ST_CTRL   = 4;
  localparam int ST_DMA    = 5;

  localparam logic [1:0] MODE_OFF   = 2'd0;
  localparam logic [1:0] MODE_QUIET = 2'd1;
  localparam logic [1:0] MODE_FULL  = 2'd2;

  logic              ps_clk;
  logic              ps_reset;
  logic [5:0]        in_valid;
  logic [5:0]        ready;
  scale_offset_vec_t scale_offset_data;
  phase_inc_t        tri_phase_inc_data;
  source_sel_t       source_sel_data;
  trigger_cfg_t      trigger_cfg_data;
  awg_ctrl_t         awg_ctrl_data;
  dma_beat_t         awg_dma_data;
  dac_out_t          dac_out;
  logic              dac_trigger;

  // expected output per cycle, filled ahead of time by the stimulus
  logic [1:0]  exp_mode [LOG_LEN];
  sample_vec_t exp_samples [LOG_LEN];
  logic        exp_trigger [LOG_LEN];
  logic        exp_busy [LOG_LEN];

  sample_vec_t frame [40];
  int          cycle;
  int          xfer_edge;
  int          play_end;
  int          errors;
  int          errors_before;
  int          tests_run;
  int          failed_tests;
  logic        timed_out;
  logic [31:0] rnd;
  logic [31:0] rng_state = 32'd64;

  transmit_tb_clock #(.PERIOD(20)) clock_gen (.ps_clk);

  transmit_top i_dut (
    .ps_clk, .ps_reset,
    .scale_offset_valid (in_valid[ST_SCALE]), .scale_offset_ready (ready[ST_SCALE]),
    .scale_offset_data,
    .tri_phase_inc_valid (in_valid[ST_PHASE]), .tri_phase_inc_ready (ready[ST_PHASE]),
    .tri_phase_inc_data,
    .source_sel_valid (in_valid[ST_SOURCE]), .source_sel_ready (ready[ST_SOURCE]),
    .source_sel_data,
    .trigger_cfg_valid (in_valid[ST_TRIG]), .trigger_cfg_ready (ready[ST_TRIG]),
    .trigger_cfg_data,
    .awg_ctrl_valid (in_valid[ST_CTRL]), .awg_ctrl_ready (ready[ST_CTRL]), .awg_ctrl_data,
    .awg_dma_valid (in_valid[ST_DMA]), .awg_dma_ready (ready[ST_DMA]), .awg_dma_data,
    .dac_out, .dac_trigger
  );

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // scale with 16 fraction bits, floor shift, offset in top 14 bits, then clamp
  function automatic sample_t prescale_ref(input sample_t x, input scale_offset_t c);
    longint prod;
    longint sum;
    prod = longint'(x) * longint'(c.scale);
    sum  = (prod >>> 16) + longint'($signed(c.offset)) * 4;
    if (sum > SAT_HI) begin
      sum = SAT_HI;
    end else if (sum < SAT_LO) begin
      sum = SAT_LO;
    end
    return sample_t'(sum);
  endfunction

  // fold the bits under the phase MSB, then flip the sign bit
  function automatic sample_t triangle_ref(input logic [`TX_PHASE_W-1:0] phase);
    logic [`TX_SAMPLE_W-1:0] bits;
    bits = phase[`TX_PHASE_W-2 -: `TX_SAMPLE_W];
    if (phase[`TX_PHASE_W-1]) begin
      bits = ~bits;
    end
    bits[`TX_SAMPLE_W-1] = ~bits[`TX_SAMPLE_W-1];
    return sample_t'(bits);
  endfunction

  function automatic sample_vec_t expect_vec(input sample_vec_t raw);
    sample_vec_t v;
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      v[ch] = prescale_ref(raw[ch], scale_offset_data[ch]);
    end
    return v;
  endfunction

  function automatic void set_expect(input int c, input sample_vec_t v, input logic trig);
    if (c < LOG_LEN) begin
      exp_mode[c]    = MODE_FULL;
      exp_samples[c] = v;
      exp_trigger[c] = trig;
    end
  endfunction

  always @(posedge ps_clk) begin
    cycle <= cycle + 1;
  end

  // compare the DUT outputs against the prediction on every falling edge
  always @(negedge ps_clk) begin
    if (cycle < LOG_LEN) begin
      if (exp_mode[cycle] != MODE_OFF) begin
        if (dac_out.valid !== (exp_mode[cycle] == MODE_FULL)) begin
          errors++;
          $display("MISMATCH cycle %0d dac_out.valid got %h expected %h",
                   cycle, dac_out.valid, exp_mode[cycle] == MODE_FULL);
        end
        if (dac_trigger !== exp_trigger[cycle]) begin
          errors++;
          $display("MISMATCH cycle %0d dac_trigger got %h expected %h",
                   cycle, dac_trigger, exp_trigger[cycle]);
        end
        if (exp_mode[cycle] == MODE_FULL && dac_out.samples !== exp_samples[cycle]) begin
          errors++;
          $display("MISMATCH cycle %0d dac_out.samples got %h expected %h",
                   cycle, dac_out.samples, exp_samples[cycle]);
        end
      end
      if (exp_busy[cycle] === 1'b1 && ready[ST_DMA] !== 1'b0) begin
        errors++;
        $display("MISMATCH cycle %0d awg_dma_ready got %h expected 0", cycle, ready[ST_DMA]);
      end
    end
  end

  // call on a falling edge; returns on the falling edge after the transfer
  task automatic transfer(input int idx);
    int waited;
    waited = 0;
    if (timed_out) begin
      return;
    end
    in_valid[idx] = 1'b1;
    while (ready[idx] !== 1'b1 && !timed_out) begin
      @(negedge ps_clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        errors++;
        timed_out = 1'b1;
        $display("timeout: stream %0d never became ready", idx);
      end
    end
    if (!timed_out) begin
      xfer_edge = cycle + 1;
      @(posedge ps_clk);
      @(negedge ps_clk);
    end
    in_valid[idx] = 1'b0;
  endtask

  task automatic wait_until(input int c);
    int waited;
    waited = 0;
    while (cycle <= c && !timed_out) begin
      @(negedge ps_clk);
      waited++;
      if (waited > LOG_LEN) begin
        errors++;
        timed_out = 1'b1;
        $display("timeout: cycle %0d was never reached", c);
      end
    end
  endtask

  task automatic set_unity();
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      scale_offset_data[ch].scale  = `TX_SCALE_W'('h10000);
      scale_offset_data[ch].offset = '0;
    end
    transfer(ST_SCALE);
  endtask

  task automatic select_source(input source_t s);
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      source_sel_data[ch] = s;
    end
    transfer(ST_SOURCE);
  endtask

  task automatic set_triggers(input logic use_awg, input logic use_tri);
    trigger_cfg_data.use_awg = use_awg;
    trigger_cfg_data.use_tri = use_tri;
    transfer(ST_TRIG);
  endtask

  task automatic fill_random(input int beats);
    for (int k = 0; k < beats; k++) begin
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        frame[k][ch] = sample_t'(xorshift32());
      end
    end
  endtask

  task automatic load_frame(input int beats);
    for (int k = 0; k < beats; k++) begin
      awg_dma_data.samples = frame[k];
      awg_dma_data.last    = (k == beats - 1);
      transfer(ST_DMA);
    end
  endtask

  // entry 0 reaches dac_out three edges after the control transfer
  task automatic start_awg(input int depth, input int bursts, input logic trig_on);
    int t0;
    awg_ctrl_data.start       = 1'b1;
    awg_ctrl_data.stop        = 1'b0;
    awg_ctrl_data.burst_count = bursts[`TX_BURST_W-1:0];
    transfer(ST_CTRL);
    t0 = xfer_edge + 3;
    for (int i = 0; i < depth * bursts + 4; i++) begin
      if (i < depth * bursts) begin
        set_expect(t0 + i, expect_vec(frame[i % depth]), trig_on && (i % depth == 0));
      end else begin
        set_expect(t0 + i, expect_vec('0), 1'b0);
      end
    end
    for (int c = xfer_edge + 1; c <= xfer_edge + depth * bursts && c < LOG_LEN; c++) begin
      exp_busy[c] = 1'b1;
    end
    play_end = t0 + depth * bursts + 4;
  endtask

  // phases restart on the update, trigger follows each channel-0 wrap
  task automatic start_triangle(input int n, input logic trig_on);
    phase_inc_t              ph;
    phase_inc_t              ph_next;
    sample_vec_t             raw;
    logic                    wrap;
    int                      t0;
    transfer(ST_PHASE);
    t0   = xfer_edge + 3;
    ph   = '0;
    wrap = 1'b0;
    for (int k = 0; k < n; k++) begin
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        raw[ch] = triangle_ref(ph[ch]);
      end
      set_expect(t0 + k, expect_vec(raw), trig_on & wrap);
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        ph_next[ch] = ph[ch] + tri_phase_inc_data[ch];
      end
      // an unsigned phase that gets smaller has gone past the top
      wrap = (ph_next[0] < ph[0]);
      ph   = ph_next;
    end
    play_end = t0 + n;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: fail, %0d errors", tests_run, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  initial begin
    ps_reset           = 1'b1;
    in_valid           = '0;
    scale_offset_data  = '0;
    tri_phase_inc_data = '0;
    trigger_cfg_data   = '0;
    awg_ctrl_data      = '0;
    awg_dma_data       = '0;
    timed_out          = 1'b0;
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      source_sel_data[ch] = src_zero;
    end
    for (int c = 0; c < LOG_LEN; c++) begin
      exp_mode[c]    = MODE_OFF;
      exp_samples[c] = '0;
      exp_trigger[c] = 1'b0;
      exp_busy[c]    = 1'b0;
    end

    // reset for two edges, valid rises on the third edge after release
    for (int c = 1; c <= 4; c++) begin
      exp_mode[c] = MODE_QUIET;
    end
    for (int c = 5; c <= 10; c++) begin
      set_expect(c, '0, 1'b0);
    end
    wait_until(1);
    ps_reset = 1'b0;
    wait_until(5);
    if (ready !== 6'h3f) begin
      errors++;
      $display("MISMATCH ready outputs got %h expected 3f", ready);
    end
    wait_until(10);
    // with unity gain the zero source must still give zero samples
    set_unity();
    for (int c = xfer_edge + 1; c <= xfer_edge + 6; c++) begin
      set_expect(c, '0, 1'b0);
    end
    wait_until(xfer_edge + 6);
    finish_test("reset state");

    set_unity();
    select_source(src_awg);
    set_triggers(1'b1, 1'b0);
    fill_random(12);
    load_frame(12);
    start_awg(12, 3, 1'b1);
    wait_until(play_end);
    finish_test("awg playback");

    // channel 1 gain of at least 3 saturates full-scale entries both ways
    rnd = xorshift32();
    scale_offset_data[0].scale  = rnd[17:0];
    scale_offset_data[0].offset = rnd[31:18];
    rnd = xorshift32();
    scale_offset_data[1].scale  = {2'b11, rnd[15:0]};
    scale_offset_data[1].offset = rnd[31:18];
    transfer(ST_SCALE);
    fill_random(16);
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      frame[0][ch] = sample_t'(SAT_HI);
      frame[1][ch] = sample_t'(SAT_LO);
    end
    load_frame(16);
    start_awg(16, 1, 1'b1);
    wait_until(play_end);
    finish_test("prescaler arithmetic");

    set_unity();
    select_source(src_tri);
    set_triggers(1'b0, 1'b0);
    tri_phase_inc_data[0] = xorshift32();
    tri_phase_inc_data[1] = xorshift32();
    start_triangle(64, 1'b0);
    wait_until(play_end);
    finish_test("triangle generation");

    // large channel-0 step so several wraps fall in the window
    set_triggers(1'b0, 1'b1);
    tri_phase_inc_data[0] = xorshift32() | 32'h0800_0000;
    tri_phase_inc_data[1] = xorshift32();
    start_triangle(80, 1'b1);
    wait_until(play_end);
    set_triggers(1'b0, 1'b0);
    select_source(src_awg);
    start_awg(16, 2, 1'b0);
    wait_until(play_end);
    finish_test("trigger routing");

    // 40 beats clamp to a 32 entry frame, stop lands in the second frame
    set_triggers(1'b1, 1'b0);
    fill_random(40);
    load_frame(40);
    start_awg(32, 3, 1'b1);
    wait_until(xfer_edge + 50);
    awg_ctrl_data.start       = 1'b0;
    awg_ctrl_data.stop        = 1'b1;
    awg_ctrl_data.burst_count = '0;
    transfer(ST_CTRL);
    for (int c = xfer_edge + 1; c <= play_end && c < LOG_LEN; c++) begin
      exp_busy[c] = 1'b0;
      if (c >= xfer_edge + 2) begin
        set_expect(c, expect_vec('0), 1'b0);
      end
    end
    wait_until(play_end);
    finish_test("stop and overflow");

    $display("totals: %0d tests, %0d failed, %0d errors", tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+logic
logic/transmit_pkg.sv
logic/config_reg.sv
logic/awg_buffer.sv
logic/triangle_gen.sv
logic/source_select.sv
logic/sample_prescaler.sv
logic/trigger_manager.sv
logic/transmit_top.sv
tb/transmit_tb_clock.sv
tb/transmit_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the transmit path testbench with Verilator, run it, check the log.
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module transmit_top_tb -f src.f -o transmit_sim

./obj_dir/transmit_sim > sim.log
cat sim.log

# the run passes only if the testbench reported success
grep -q "Verification passed" sim.log
